/* list.f */
hdl/g729_ops_pkg.sv
hdl/l_shl_iter.sv
hdl/l_shr_iter.sv
hdl/norm_l_iter.sv
hdl/op_dispatch.sv
hdl/basic_op_unit.sv
bench/basic_op_unit_tb.sv

/* Bender.yml */
package:
  name: basic_op_unit

sources:
  - hdl/g729_ops_pkg.sv
  - hdl/l_shl_iter.sv
  - hdl/l_shr_iter.sv
  - hdl/norm_l_iter.sv
  - hdl/op_dispatch.sv
  - hdl/basic_op_unit.sv
  - target: test
    files:
      - bench/basic_op_unit_tb.sv

/* bench/basic_op_unit_tb.sv */
`timescale 1ns/100ps

module basic_op_unit_tb;
	import g729_ops_pkg::*;

	localparam int NUM_OPS         = 200;  // upper bound on operations below
	localparam int MAX_OP_CYCLES   = 40;   // worst operator latency plus slack
	localparam int WATCHDOG_CYCLES = NUM_OPS * MAX_OP_CYCLES + 500;
	localparam logic [15:0] LFSR_TAPS = 16'hb400;  // x^16+x^14+x^13+x^11+1

	logic   clk;
	logic   reset;
	logic   start;
	op_t    op;
	word_t  var1;
	shift_t num_shift;
	logic   clear_overflow;
	logic   busy;
	logic   done;
	word_t  result;
	logic   overflow;

	int          errors;
	int          checks;
	logic        exp_ovf;     // sticky flag as the model sees it
	logic [15:0] lfsr_state;

	basic_op_unit dut_i (
		.clk            (clk),
		.reset          (reset),
		.start          (start),
		.op             (op),
		.var1           (var1),
		.num_shift      (num_shift),
		.clear_overflow (clear_overflow),
		.busy           (busy),
		.done           (done),
		.result         (result),
		.overflow       (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////// helpers
	// galois lfsr, one step per bit handed out
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] acc;
		logic        b;
		int          i;
		acc = '0;
		for (i = 0; i < n; i++) begin
			b          = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (b)
				lfsr_state = lfsr_state ^ LFSR_TAPS;
			acc = {acc[30:0], b};
		end
		return acc;
	endfunction

	// expected result straight from the operator definitions
	function automatic void model(input op_t o, input word_t v, input shift_t n,
			output word_t res, output logic sat);
		longint p;
		int     i;
		res = '0;
		sat = 1'b0;
		case (o)
			OP_L_SHL: begin
				if (n < 0)
					res = NEG_SHIFT_RESULT;
				else if (v == 0)
					res = '0;
				else if (n >= 32) begin
					sat = 1'b1;  // any nonzero value overflows
					res = (v < 0) ? MIN_32 : MAX_32;
				end else begin
					p = longint'(v) * (longint'(1) << n);  // exact product, 64 bits
					if (p > longint'(MAX_32)) begin
						sat = 1'b1;
						res = MAX_32;
					end else if (p < longint'(MIN_32)) begin
						sat = 1'b1;
						res = MIN_32;
					end else
						res = word_t'(p);
				end
			end
			OP_L_SHR: begin
				if (n < 0)
					res = NEG_SHIFT_RESULT;
				else if (n >= 31)
					res = (v < 0) ? ALL_ONES : '0;  // only sign left
				else
					res = v >>> n;
			end
			OP_NORM_L: begin
				if (v == 0)
					res = '0;
				else if (v == ALL_ONES)
					res = 32'sd31;
				else begin
					// count bits below the sign that repeat it
					i = 30;
					while (i >= 0 && v[i] == v[31]) begin
						res = res + 1;
						i--;
					end
				end
			end
			default: ;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		checks++;
		assert (act_val === exp_val)
		else begin
			$display("CHECK FAILED at %0t: %s expected %h actual %h",
				$time, name, exp_val, act_val);
			errors++;
		end
	endtask

	// pulse start, wait for done, hand back result and flag
	task automatic run_op(input op_t o, input word_t v, input shift_t n,
			output word_t res, output logic ovf);
		int cycles;
		start     = 1'b1;
		op        = o;
		var1      = v;
		num_shift = n;
		@(posedge clk);
		#1;
		start  = 1'b0;   // operands held until done
		cycles = 0;
		while (!done && cycles < MAX_OP_CYCLES) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		checks++;
		assert (done)
		else begin
			$display("no done within %0d cycles at %0t (op %0d)", MAX_OP_CYCLES, $time, o);
			errors++;
		end
		check_value("busy", 1'b0, busy);  // falls with done
		res = result;
		ovf = overflow;
	endtask

	task automatic check_op(input op_t o, input word_t v, input shift_t n);
		word_t exp_res;
		logic  sat;
		word_t got;
		logic  got_ovf;
		model(o, v, n, exp_res, sat);
		if (sat)
			exp_ovf = 1'b1;  // sticky
		run_op(o, v, n, got, got_ovf);
		check_value("result", exp_res, got);
		check_value("overflow", exp_ovf, got_ovf);
	endtask

	task automatic clear_ovf();
		clear_overflow = 1'b1;
		@(posedge clk);
		#1;
		clear_overflow = 1'b0;
		exp_ovf        = 1'b0;
		check_value("overflow", exp_ovf, overflow);
	endtask

	////////////////////////////// tests
	task automatic test_reset();
		check_value("busy", 1'b0, busy);
		check_value("done", 1'b0, done);
		check_value("overflow", 1'b0, overflow);
		check_value("result", '0, result);
	endtask

	task automatic test_shl();
		check_op(OP_L_SHL, 32'sd5, 16'sd3);  // in range
		check_op(OP_L_SHL, -32'sd7, 16'sd4);
		check_op(OP_L_SHL, 32'sh0000_1234, 16'sd16);
		check_op(OP_L_SHL, 32'sd1, 16'sd30);
		check_op(OP_L_SHL, ALL_ONES, 16'sd31);  // lands exactly on MIN_32
		check_op(OP_L_SHL, 32'sh4000_0000, 16'sd1);  // saturates high
		check_op(OP_L_SHL, 32'sd5, 16'sd1);          // flag must survive
		clear_ovf();
		check_op(OP_L_SHL, -32'sh4000_0001, 16'sd1);  // saturates low
		check_op(OP_L_SHR, 32'sd100, 16'sd2);
		clear_ovf();
		check_op(OP_L_SHL, 32'sd1234, -16'sd1);  // negative count
		check_op(OP_L_SHL, 32'sh1234_5678, 16'sd0);
	endtask

	task automatic test_shr();
		shift_t counts [6];
		word_t  vals [2];
		int     i;
		int     j;
		counts = '{16'sd0, 16'sd1, 16'sd15, 16'sd31, 16'sd40, -16'sd3};
		vals   = '{32'sh7654_3210, 32'shedcb_a987};
		for (i = 0; i < 2; i++)
			for (j = 0; j < 6; j++)
				check_op(OP_L_SHR, vals[i], counts[j]);
	endtask

	task automatic test_norm();
		word_t v;
		int    i;
		check_op(OP_NORM_L, '0, 16'sd0);
		check_op(OP_NORM_L, ALL_ONES, 16'sd0);
		check_op(OP_NORM_L, MIN_32, 16'sd0);
		check_op(OP_NORM_L, MAX_32, 16'sd0);
		check_op(OP_NORM_L, 32'sd1, 16'sd0);
		for (i = 0; i < 50; i++) begin
			v = lfsr_bits(32);
			v = v >>> lfsr_bits(5);  // spread the norm counts
			check_op(OP_NORM_L, v, 16'sd0);
		end
	endtask

	// second start lands mid operation and must vanish
	task automatic test_busy_ignore();
		word_t exp_res;
		logic  sat;
		word_t got;
		int    dones;
		int    cycles;
		model(OP_L_SHL, 32'sd3, 16'sd20, exp_res, sat);
		got       = '0;
		start     = 1'b1;
		op        = OP_L_SHL;
		var1      = 32'sd3;
		num_shift = 16'sd20;
		@(posedge clk);
		#1;
		start = 1'b0;
		@(posedge clk);
		#1;   // operator has its operands now
		check_value("busy", 1'b1, busy);
		start     = 1'b1;
		op        = OP_NORM_L;
		var1      = 32'sh0000_0100;
		num_shift = 16'sd0;
		@(posedge clk);
		#1;
		start  = 1'b0;
		dones  = 0;
		cycles = 0;
		while (cycles < 60) begin
			if (done) begin
				dones++;
				got = result;
			end
			@(posedge clk);
			#1;
			cycles++;
		end
		check_value("done count", 32'd1, dones);
		check_value("result", exp_res, got);
		check_value("overflow", exp_ovf, overflow);
	endtask

	task automatic test_mixed();
		op_t    o;
		word_t  v;
		shift_t n;
		int     i;
		for (i = 0; i < 100; i++) begin
			o = op_t'(lfsr_bits(2));
			while (o == 2'd3)
				o = op_t'(lfsr_bits(2));  // redraw the illegal code
			v = lfsr_bits(32);
			v = v >>> lfsr_bits(5);
			n = shift_t'(lfsr_bits(6)) - 16'sd8;  // -8 up to 55
			check_op(o, v, n);
			if (lfsr_bits(2) == 2'b11)
				clear_ovf();
		end
	endtask

	////////////////////////////// main
	initial begin
		errors         = 0;
		checks         = 0;
		exp_ovf        = 1'b0;
		lfsr_state     = 16'd60438;
		reset          = 1'b1;
		start          = 1'b0;
		op             = OP_L_SHL;
		var1           = '0;
		num_shift      = '0;
		clear_overflow = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset();
		test_shl();
		test_shr();
		test_norm();
		test_busy_ignore();
		test_mixed();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// a stuck operator ends here
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* hdl/basic_op_unit.sv */
`timescale 1ns/100ps

module basic_op_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,           // strobe
	input  g729_ops_pkg::op_t    op,
	input  g729_ops_pkg::word_t  var1,
	input  g729_ops_pkg::shift_t num_shift,
	input  logic                 clear_overflow,  // strobe
	output logic                 busy,
	output logic                 done,            // one cycle pulse
	output g729_ops_pkg::word_t  result,
	output logic                 overflow         // sticky
);
	import g729_ops_pkg::*;

	// per operator strobes and results
	logic  shl_ready;
	logic  shr_ready;
	logic  norm_ready;
	logic  shl_done;
	logic  shr_done;
	logic  norm_done;
	logic  shl_overflow;
	word_t shl_out;
	word_t shr_out;
	word_t norm_out;

	////////////////////////////// control
	op_dispatch dispatch_i (
		.clk            (clk),
		.reset          (reset),
		.start          (start),
		.op             (op),
		.clear_overflow (clear_overflow),
		.shl_done       (shl_done),
		.shl_overflow   (shl_overflow),
		.shl_out        (shl_out),
		.shr_done       (shr_done),
		.shr_out        (shr_out),
		.norm_done      (norm_done),
		.norm_out       (norm_out),
		.busy           (busy),
		.done           (done),
		.result         (result),
		.overflow       (overflow),
		.shl_ready      (shl_ready),
		.shr_ready      (shr_ready),
		.norm_ready     (norm_ready)
	);

	////////////////////////////// operators
	// operands fan out to all three, each latches on its own ready
	l_shl_iter shl_i (
		.clk       (clk),
		.reset     (reset),
		.ready     (shl_ready),
		.var1      (var1),
		.num_shift (num_shift),
		.done      (shl_done),
		.overflow  (shl_overflow),
		.out       (shl_out)
	);

	l_shr_iter shr_i (
		.clk       (clk),
		.reset     (reset),
		.ready     (shr_ready),
		.var1      (var1),
		.num_shift (num_shift),
		.done      (shr_done),
		.out       (shr_out)
	);

	norm_l_iter norm_i (
		.clk   (clk),
		.reset (reset),
		.ready (norm_ready),
		.var1  (var1),
		.done  (norm_done),
		.out   (norm_out)
	);

endmodule

/* hdl/op_dispatch.sv */
`timescale 1ns/100ps

module op_dispatch (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,           // strobe, taken only when idle
	input  g729_ops_pkg::op_t   op,              // sampled with start
	input  logic                clear_overflow,  // strobe
	input  logic                shl_done,
	input  logic                shl_overflow,
	input  g729_ops_pkg::word_t shl_out,
	input  logic                shr_done,
	input  g729_ops_pkg::word_t shr_out,
	input  logic                norm_done,
	input  g729_ops_pkg::word_t norm_out,
	output logic                busy,
	output logic                done,            // one cycle after operator done
	output g729_ops_pkg::word_t result,          // held until next done
	output logic                overflow,        // sticky Overflow flag
	output logic                shl_ready,
	output logic                shr_ready,
	output logic                norm_ready
);
	import g729_ops_pkg::*;

	op_t   sel;        // operation in flight
	logic  op_legal;
	logic  accept;
	logic  sel_done;   // done of the selected operator
	word_t sel_out;
	logic  finish;
	logic  ovf_set;

	assign op_legal = op inside {OP_L_SHL, OP_L_SHR, OP_NORM_L};
	assign accept   = start && !busy && op_legal;  // code 3 dropped

	////////////////////////////// result select
	always_comb begin
		sel_done = 1'b0;
		sel_out  = shl_out;
		case (sel)
			OP_L_SHL: begin
				sel_done = shl_done;
				sel_out  = shl_out;
			end
			OP_L_SHR: begin
				sel_done = shr_done;
				sel_out  = shr_out;
			end
			OP_NORM_L: begin
				sel_done = norm_done;
				sel_out  = norm_out;
			end
			default: ;
		endcase
	end

	assign finish  = busy && sel_done;
	assign ovf_set = finish && (sel == OP_L_SHL) && shl_overflow;  // only shl saturates

	////////////////////////////// sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			done       <= 1'b0;
			sel        <= OP_L_SHL;
			result     <= '0;
			overflow   <= 1'b0;
			shl_ready  <= 1'b0;
			shr_ready  <= 1'b0;
			norm_ready <= 1'b0;
		end else begin
			done       <= 1'b0;
			shl_ready  <= 1'b0;  // readies last one cycle
			shr_ready  <= 1'b0;
			norm_ready <= 1'b0;
			if (accept) begin
				busy       <= 1'b1;
				sel        <= op;
				shl_ready  <= op == OP_L_SHL;
				shr_ready  <= op == OP_L_SHR;
				norm_ready <= op == OP_NORM_L;
			end else if (finish) begin
				busy   <= 1'b0;
				done   <= 1'b1;
				result <= sel_out;
			end
			// set beats clear in the same cycle
			if (ovf_set)
				overflow <= 1'b1;
			else if (clear_overflow)
				overflow <= 1'b0;
		end
	end

	// operators only run one at a time
	one_done_a: assert property (@(posedge clk) disable iff (reset)
		$onehot0({shl_done, shr_done, norm_done}));
	legal_op_a: assert property (@(posedge clk) disable iff (reset)
		start && !busy |-> op_legal);
	// one ready at a time, never while an operator still reports done
	ready_onehot_a: assert property (@(posedge clk) disable iff (reset)
		(shl_ready || shr_ready || norm_ready) |->
			$onehot({shl_ready, shr_ready, norm_ready}) &&
			!(shl_done || shr_done || norm_done));

endmodule

/* hdl/norm_l_iter.sv */
`timescale 1ns/100ps

module norm_l_iter (
	input  logic                clk,
	input  logic                reset,
	input  logic                ready,      // start strobe, seen only in idle
	input  g729_ops_pkg::word_t var1,
	output logic                done,       // one cycle, out valid
	output g729_ops_pkg::word_t out         // shift count, zero extended
);
	import g729_ops_pkg::*;

	localparam int CNT_W = 6;  // one spare bit so an overrun is visible

	typedef enum logic {
		IDLE,
		NORM
	} state_t;

	state_t           state;
	word_t            val;   // shifted copy of var1
	logic [CNT_W-1:0] cnt;   // redundant sign bits seen so far
	logic             is_zero;
	logic             is_ones;
	logic             normed;

	assign is_zero = var1 == 0;
	assign is_ones = var1 == ALL_ONES;
	assign normed  = val[WORD_W-1] != val[WORD_W-2];  // top two bits differ

	////////////////////////////// control
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (ready && (is_zero || is_ones))
						done <= 1'b1;   // answered without a loop
					else if (ready)
						state <= NORM;
				end
				NORM: begin
					if (normed) begin
						done  <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////// datapath
	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (ready) begin
					val <= var1;
					cnt <= '0;
					if (is_zero)
						out <= '0;
					else if (is_ones)
						out <= NORM_MAX;    // codec returns 31 for -1
				end
			end
			NORM: begin
				if (normed)
					out <= {{(WORD_W-CNT_W){1'b0}}, cnt};
				else begin
					val <= val <<< 1;
					cnt <= cnt + 1'b1;
				end
			end
			default: ;
		endcase
	end

	// zero and -1 are kept out of the loop, so it ends by 30
	cnt_range_a: assert property (@(posedge clk) disable iff (reset)
		state == NORM |-> cnt <= NORM_MAX);

endmodule

/* hdl/l_shr_iter.sv */
`timescale 1ns/100ps

module l_shr_iter (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ready,      // start strobe, seen only in idle
	input  g729_ops_pkg::word_t  var1,
	input  g729_ops_pkg::shift_t num_shift,
	output logic                 done,       // one cycle, out valid
	output g729_ops_pkg::word_t  out
);
	import g729_ops_pkg::*;

	typedef enum logic {
		IDLE,
		SHIFT
	} state_t;

	state_t state;
	word_t  val;        // value being halved
	shift_t cnt;        // shifts still owed
	logic   neg_count;
	logic   stop;

	assign neg_count = num_shift[SHIFT_W-1];

	// 0 and -1 are fixed points of >>>, so big counts end within 32 clocks
	assign stop = (cnt == 0) || (val == 0) || (val == ALL_ONES);

	////////////////////////////// control
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (ready && neg_count)
						done <= 1'b1;   // same convention as l_shl
					else if (ready)
						state <= SHIFT;
				end
				SHIFT: begin
					if (stop) begin
						done  <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////// datapath
	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (ready) begin
					val <= var1;
					cnt <= num_shift;
					if (neg_count)
						out <= NEG_SHIFT_RESULT;
				end
			end
			SHIFT: begin
				if (stop)
					out <= val;
				else begin
					val <= val >>> 1;             // sign fill
					cnt <= cnt - shift_t'(1);
				end
			end
			default: ;
		endcase
	end

endmodule

/* hdl/l_shl_iter.sv */
`timescale 1ns/100ps

module l_shl_iter (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ready,      // start strobe, seen only in idle
	input  g729_ops_pkg::word_t  var1,
	input  g729_ops_pkg::shift_t num_shift,
	output logic                 done,       // one cycle, out valid
	output logic                 overflow,   // saturation pulse, rides with done
	output g729_ops_pkg::word_t  out
);
	import g729_ops_pkg::*;

	typedef enum logic {
		IDLE,
		SHIFT
	} state_t;

	state_t state;
	word_t  val;        // value being doubled
	shift_t cnt;        // doublings still owed
	logic   neg_count;
	logic   stop;       // nothing left to do
	logic   sat_pos;
	logic   sat_neg;

	assign neg_count = num_shift[SHIFT_W-1];

	// zero never overflows, so it stops right away
	assign stop    = (cnt == 0) || (val == 0);
	assign sat_pos = val > SHL_SAFE_MAX;  // next doubling passes MAX_32
	assign sat_neg = val < SHL_SAFE_MIN;  // next doubling passes MIN_32

	////////////////////////////// control
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= IDLE;
			done     <= 1'b0;
			overflow <= 1'b0;
		end else begin
			done     <= 1'b0;  // pulse by default
			overflow <= 1'b0;
			case (state)
				IDLE: begin
					if (ready && neg_count) begin
						done <= 1'b1;  // no shifting at all
					end else if (ready) begin
						state <= SHIFT;
					end
				end
				SHIFT: begin
					if (stop) begin
						done  <= 1'b1;
						state <= IDLE;
					end else if (sat_pos || sat_neg) begin
						done     <= 1'b1;  // early end on saturation
						overflow <= 1'b1;
						state    <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////// datapath
	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (ready) begin
					val <= var1;       // latch operands
					cnt <= num_shift;
					if (neg_count)
						out <= NEG_SHIFT_RESULT;
				end
			end
			SHIFT: begin
				if (stop)
					out <= val;
				else if (sat_pos)
					out <= MAX_32;
				else if (sat_neg)
					out <= MIN_32;
				else begin
					val <= val <<< 1;             // one bit per clock
					cnt <= cnt - shift_t'(1);
				end
			end
			default: ;
		endcase
	end

	// saturation ends the operation on the rail of the value's sign
	ovf_with_done_a: assert property (@(posedge clk) disable iff (reset)
		overflow |-> done && (out == ((val < 0) ? MIN_32 : MAX_32)));
	// dispatcher cannot restart us back to back
	done_single_a: assert property (@(posedge clk) disable iff (reset)
		done |=> !done);

endmodule

/* hdl/g729_ops_pkg.sv */
package g729_ops_pkg;

	////////////////////////////// widths
	// word sizes fixed by the codec
	localparam int WORD_W  = 32;  // Word32
	localparam int SHIFT_W = 16;  // Word16 shift count

	typedef logic signed [WORD_W-1:0]  word_t;   // operand and result word
	typedef logic signed [SHIFT_W-1:0] shift_t;  // signed shift count

	////////////////////////////// limits
	// saturation rails of L_ operators
	localparam word_t MAX_32 = 32'sh7fff_ffff;
	localparam word_t MIN_32 = 32'sh8000_0000;

	// doubling stays in range between these two
	localparam word_t SHL_SAFE_MAX = 32'sh3fff_ffff;
	localparam word_t SHL_SAFE_MIN = 32'shc000_0000;

	localparam word_t ALL_ONES = '1;  // -1
	localparam word_t NEG_SHIFT_RESULT = ALL_ONES;  // negative count answer

	// norm_l of all ones, also the largest legal count
	localparam word_t NORM_MAX = 32'sd31;

	////////////////////////////// opcodes
	// code 3 left unassigned, illegal
	typedef enum logic [1:0] {
		OP_L_SHL  = 2'd0,  // saturating left shift
		OP_L_SHR  = 2'd1,  // arithmetic right shift
		OP_NORM_L = 2'd2   // normalisation count
	} op_t;

endpackage
